// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Isrc -f vlog.f --top-module icache_tb \
		-Mdir obj_dir -o icache_sim
	./obj_dir/icache_sim | tee /dev/stderr | grep -q "All tests passed"

lint:
	verilator --lint-only --timing -Isrc -f vlog.f --top-module icache_tb

clean:
	rm -rf obj_dir

// File: dv/icache_properties.sv
`timescale 1ns/100ps
`default_nettype none

module icache_properties #(
    parameter bit REFILL_SIDE = 1'b1
) (
    input logic        clk,
    input logic        reset,
    input logic        req,
    input logic [31:0] addr,
    input logic        ret_valid,
    input logic        fill_valid,
    input logic        branch_flush,
    input logic        stall
);

    logic flushed;  // flush seen while the line is still owed

    always_ff @(posedge clk) begin
        if (reset) begin
            flushed <= 1'b0;
        end else if (req && branch_flush) begin
            flushed <= 1'b1;
        end else if (!req) begin
            flushed <= 1'b0;
        end
    end

    if (REFILL_SIDE) begin : g_refill
        a_req_hold: assert property (@(posedge clk) disable iff (reset)
            req && !ret_valid |=> req && $stable(addr))
            else $error("read request dropped or address changed before the line returned");

        a_no_fill: assert property (@(posedge clk) disable iff (reset)
            req && ret_valid && (flushed || branch_flush) |=> !fill_valid)
            else $error("line written after its request was flushed");
    end else begin : g_stall
        a_stall: assert property (@(posedge clk) disable iff (reset) req |-> stall)
            else $error("front end not stalled during a refill");
    end

endmodule : icache_properties

`default_nettype wire

// File: dv/icache_tb.sv
`timescale 1ns/100ps
`default_nettype none

module icache_tb;

    import fetch_pkg::*;

    localparam int NUM_RANDOM   = 400;
    localparam int NUM_FETCHES  = NUM_RANDOM + 16;
    localparam int WORST_CYCLES = 24;  // 7 memory cycles plus lookup, fill and replay
    localparam int WAIT_LIMIT   = 40;

    logic       clk;
    logic       reset;
    logic       fetch_valid;
    bus32_t     fetch_pc;
    logic       branch_flush;
    logic       fetch_stall;
    logic [1:0] inst_valid;
    inst_pair_t inst;
    bus32_t     inst_pc;
    logic       rd_req;
    bus32_t     rd_addr;
    logic       ret_valid;
    bus256_t    ret_data;

    bus32_t      mem [256];  // 4 tags x 8 sets x 8 words
    logic [19:0] m_tag [8][2];
    logic        m_vld [8][2];
    logic        m_lru [8];  // way replaced next
    int          errors;
    int          req_count;
    int          resp_count;
    int          exp_misses;
    int          exp_resps;
    logic        rd_req_d;

    icache_top DUT (.*);

    bind refill_unit icache_properties #(.REFILL_SIDE(1'b1)) u_refill_props (
        .clk(clk), .reset(reset), .req(rd_req), .addr(rd_addr), .ret_valid(ret_valid),
        .fill_valid(fill_valid), .branch_flush(branch_flush), .stall(1'b0)
    );
    bind icache_top icache_properties #(.REFILL_SIDE(1'b0)) u_stall_props (
        .clk(clk), .reset(reset), .req(rd_req), .addr(rd_addr), .ret_valid(ret_valid),
        .fill_valid(fill_valid), .branch_flush(branch_flush), .stall(fetch_stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic bus32_t make_pc(int t, int s, int w);
        return bus32_t'((t << 12) | (s << 5) | (w << 2));
    endfunction

    function automatic bus32_t mem_word(bus32_t a);
        return mem[{a[13:12], a[7:5], a[4:2]}];
    endfunction

    function automatic bus256_t mem_line(bus32_t a);
        bus256_t l;
        for (int w = 0; w < 8; w++) begin
            l[32*w +: 32] = mem_word(a + bus32_t'(4 * w));
        end
        return l;
    endfunction

    function automatic bit model_hit(bus32_t pc);
        int s;
        s = int'(pc[7:5]);
        for (int w = 0; w < 2; w++) begin
            if (m_vld[s][w] && m_tag[s][w] == pc[31:12]) return 1'b1;
        end
        return 1'b0;
    endfunction

    // hit refreshes LRU, miss fills the LRU way
    function automatic void model_access(bus32_t pc);
        int   s;
        logic v;
        s = int'(pc[7:5]);
        for (int w = 0; w < 2; w++) begin
            if (m_vld[s][w] && m_tag[s][w] == pc[31:12]) begin
                m_lru[s] = (w == 0);
                return;
            end
        end
        v = m_lru[s];
        m_vld[s][v] = 1'b1;
        m_tag[s][v] = pc[31:12];
        m_lru[s] = !v;
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic do_fetch(input bus32_t pc, input bit flush_it);
        bit     exp_hit;
        int     n;
        int     rises;
        logic   prev_req;
        bus32_t req_a;
        exp_hit = model_hit(pc);
        rises = 0;
        prev_req = 1'b0;
        req_a = '0;
        n = 0;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= pc;
        @(negedge clk);
        while (fetch_stall && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("fetch of %h was never accepted, stall stuck high", pc);
        end
        @(posedge clk);  // acceptance edge
        fetch_valid <= 1'b0;
        n = 0;
        if (flush_it && !exp_hit) begin
            exp_misses++;
            do begin
                @(negedge clk);
                n++;
            end while (!rd_req && n < WAIT_LIMIT);
            check(rd_addr, pc & 32'hffff_ffe0, "flushed miss read address");
            @(posedge clk);
            branch_flush <= 1'b1;
            @(posedge clk);
            branch_flush <= 1'b0;
            n = 0;
            do begin
                @(negedge clk);
                n++;
                check(32'(inst_valid[0]), 32'd0, "response for a flushed fetch");
            end while (fetch_stall && n < WAIT_LIMIT);
            if (n >= WAIT_LIMIT) begin
                errors++;
                $display("stall never released after flush of %h", pc);
            end
            return;
        end
        exp_resps++;
        do begin
            @(negedge clk);
            n++;
            if (rd_req && !prev_req) begin
                rises++;
                req_a = rd_addr;
            end
            prev_req = rd_req;
        end while (!inst_valid[0] && n < WAIT_LIMIT);
        if (n >= WAIT_LIMIT) begin
            errors++;
            $display("no response for fetch of %h", pc);
            return;
        end
        if (exp_hit) begin
            check(n, 2, "hit latency in cycles");
        end else begin
            exp_misses++;
            check(req_a, pc & 32'hffff_ffe0, "miss read address");
        end
        check(rises, exp_hit ? 1'b0 : 1'b1, "read requests for one fetch");
        check(inst_pc, pc, "response pc");
        check(inst[0], mem_word(pc), "slot 0 word");
        check(32'(inst_valid[1]), 32'(pc[4:2] != 3'd7), "slot 1 valid");
        if (inst_valid[1]) check(inst[1], mem_word(pc + 32'd4), "slot 1 word");
        model_access(pc);
        @(negedge clk);
        check(32'(inst_valid[0]), 32'd0, "duplicate response");
    endtask

    // counts every request and response over the whole run
    always @(negedge clk) begin
        if (!reset) begin
            if (rd_req && !rd_req_d) req_count++;
            if (inst_valid[0]) resp_count++;
        end
        rd_req_d = rd_req;
    end

    // memory answers each request after 0 to 6 idle cycles
    initial begin
        int     d;
        bus32_t a;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                a = rd_addr;
                d = int'($urandom_range(6));
                repeat (d) @(posedge clk);
                @(posedge clk);
                ret_valid <= 1'b1;
                ret_data  <= mem_line(a);
                @(posedge clk);
                ret_valid <= 1'b0;
            end
        end
    end

    initial begin
        #(NUM_FETCHES * WORST_CYCLES * 8 + 400);
        $display("timeout, the run did not finish in time");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        bit fl;
        void'($urandom(56));
        errors = 0;
        req_count = 0;
        resp_count = 0;
        exp_misses = 0;
        exp_resps = 0;
        rd_req_d = 1'b0;
        reset = 1'b1;
        fetch_valid = 1'b0;
        fetch_pc = '0;
        branch_flush = 1'b0;
        for (int i = 0; i < 256; i++) mem[i] = $urandom;
        for (int s = 0; s < 8; s++) begin
            m_lru[s] = 1'b0;
            m_vld[s][0] = 1'b0;
            m_vld[s][1] = 1'b0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check(32'(rd_req), 32'd0, "rd_req after reset");
        check(32'(fetch_stall), 32'd0, "fetch_stall after reset");
        check(32'(inst_valid), 32'd0, "inst_valid after reset");

        do_fetch(make_pc(0, 1, 2), 1'b0);  // cold miss
        do_fetch(make_pc(0, 1, 7), 1'b0);  // hit on last word
        do_fetch(make_pc(0, 1, 0), 1'b0);
        // three lines fighting over set 3
        do_fetch(make_pc(0, 3, 1), 1'b0);
        do_fetch(make_pc(1, 3, 4), 1'b0);
        do_fetch(make_pc(0, 3, 5), 1'b0);
        do_fetch(make_pc(2, 3, 0), 1'b0);
        do_fetch(make_pc(1, 3, 6), 1'b0);
        do_fetch(make_pc(0, 3, 3), 1'b0);
        do_fetch(make_pc(2, 3, 7), 1'b0);
        // flushed refill must not fill the line
        do_fetch(make_pc(3, 5, 2), 1'b1);
        do_fetch(make_pc(3, 5, 2), 1'b0);
        do_fetch(make_pc(3, 5, 3), 1'b0);

        for (int i = 0; i < NUM_RANDOM; i++) begin
            fl = ($urandom_range(7) == 0);
            do_fetch(make_pc(int'($urandom_range(3)), int'($urandom_range(7)),
                             int'($urandom_range(7))), fl);
        end

        repeat (10) @(negedge clk);
        @(posedge clk);
        check(req_count, exp_misses, "total read requests");
        check(resp_count, exp_resps, "total responses");
        $display("errors: %0d, requests: %0d, responses: %0d", errors, req_count, resp_count);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule : icache_tb

`default_nettype wire

// File: src/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // plain 32-bit word, used for pc, addresses and instructions
    typedef logic [31:0] bus32_t;

    // a full cache line as returned by memory
    // word 0 sits in bits 31:0
    typedef logic [255:0] bus256_t;

    // two instruction slots handed to the front end
    typedef bus32_t [1:0] inst_pair_t;  // [0] at pc, [1] at pc+4

endpackage : fetch_pkg

`default_nettype wire

// File: src/fetch_req_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_req_stage
    import fetch_pkg::*, icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        fetch_valid,
    input  bus32_t      fetch_pc,
    input  logic        branch_flush,
    input  logic        miss,
    input  logic        busy,
    output logic        req_valid,
    output cache_addr_u req_addr,
    output logic        fetch_stall
);

    logic replay_q;  // lookup rereads the filled set this cycle
    logic accept;

    assign fetch_stall = miss || busy || replay_q;
    assign accept      = fetch_valid && !fetch_stall && !branch_flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
            replay_q  <= 1'b0;
        end else begin
            replay_q <= busy;
            if (branch_flush) begin
                req_valid <= 1'b0;  // drop whatever was waiting
            end else if (!fetch_stall) begin
                req_valid <= fetch_valid;
            end
        end
    end

    // held unchanged through a stall
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr.raw <= fetch_pc;
        end
    end

endmodule : fetch_req_stage

`default_nettype wire

// File: src/icache_cfg.svh
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// two ways of 128 sets, 32-byte lines
// fetch address splits as tag | index | word | byte

`define ICACHE_INDEX_W    7     // set select bits
`define ICACHE_OFFSET_W   5     // byte offset inside a line
`define ICACHE_TAG_W      20    // remaining upper pc bits

`define ICACHE_SETS       128
`define ICACHE_LINE_WORDS 8

// widths above must satisfy
// tag + index + offset == 32
// 1 << index == sets
// 4 * line words == 1 << offset

`endif

// File: src/icache_lookup.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module icache_lookup
    import fetch_pkg::*, icache_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  cache_addr_u req_addr,
    input  logic        branch_flush,
    input  logic        fill_valid,
    input  bus256_t     fill_line,
    output logic        miss,
    output bus32_t      miss_addr,
    output logic [1:0]  inst_valid,
    output inst_pair_t  inst,
    output bus32_t      inst_pc
);

    localparam int WORD_W = `ICACHE_OFFSET_W - 2;
    localparam logic [WORD_W-1:0] LAST_WORD = WORD_W'(`ICACHE_LINE_WORDS - 1);

    logic [`ICACHE_SETS-1:0]    lru;        // bit set means way 1 is replaced next
    logic                       s1_valid;
    cache_addr_u                s1_addr;
    logic                       wait_fill;  // miss sent, waiting for the line
    cache_addr_u                fill_addr;
    logic [`ICACHE_INDEX_W-1:0] rd_index;
    tagv_t                      way_tagv [2];
    bus256_t                    way_line [2];
    logic [1:0]                 hit_way;
    logic                       hit;
    logic                       held;
    logic                       victim;
    bus256_t                    hit_line;
    logic [WORD_W-1:0]          word_nxt;

    // while a request waits on a refill, keep rereading its own set
    assign held     = s1_valid && !hit;
    assign rd_index = held ? s1_addr.f.index : req_addr.f.index;
    assign victim   = lru[fill_addr.f.index];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic [`ICACHE_TAG_W-1:0] tag_mem  [`ICACHE_SETS];
        bus256_t                  line_mem [`ICACHE_SETS];
        logic [`ICACHE_SETS-1:0]  vld;
        logic [`ICACHE_TAG_W-1:0] rd_tag;
        bus256_t                  rd_line;
        logic                     rd_vld;
        logic                     wr_en;

        assign wr_en = fill_valid && (victim == 1'(w));

        // read before write on the same edge
        always_ff @(posedge clk) begin
            if (wr_en) begin
                tag_mem[fill_addr.f.index]  <= fill_addr.f.tag;
                line_mem[fill_addr.f.index] <= fill_line;
            end
            rd_tag  <= tag_mem[rd_index];
            rd_line <= line_mem[rd_index];
        end

        always_ff @(posedge clk) begin
            if (reset) begin
                vld    <= '0;
                rd_vld <= 1'b0;
            end else begin
                if (wr_en) begin
                    vld[fill_addr.f.index] <= 1'b1;
                end
                rd_vld <= vld[rd_index];
            end
        end

        assign way_tagv[w] = '{valid: rd_vld, tag: rd_tag};
        assign way_line[w] = rd_line;
        assign hit_way[w]  = way_tagv[w].valid && (way_tagv[w].tag == s1_addr.f.tag);
    end

    assign hit      = |hit_way;
    assign hit_line = hit_way[1] ? way_line[1] : way_line[0];

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid  <= 1'b0;
            wait_fill <= 1'b0;
        end else if (branch_flush) begin
            s1_valid  <= 1'b0;
            wait_fill <= 1'b0;
        end else if (!held) begin
            s1_valid  <= req_valid;
            wait_fill <= 1'b0;
        end else if (miss) begin
            wait_fill <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!held) begin
            s1_addr <= req_addr;
        end
        if (miss) begin
            fill_addr <= s1_addr;  // kept even if the request is flushed
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru <= '0;
        end else if (fill_valid) begin
            lru[fill_addr.f.index] <= !victim;
        end else if (inst_valid[0]) begin
            lru[s1_addr.f.index] <= hit_way[0];
        end
    end

    assign miss      = s1_valid && !hit && !wait_fill && !branch_flush;
    assign miss_addr = s1_addr.raw;

    // slot 1 only from the same line
    assign word_nxt      = s1_addr.f.word + 1'b1;
    assign inst_valid[0] = s1_valid && hit && !branch_flush;
    assign inst_valid[1] = inst_valid[0] && (s1_addr.f.word != LAST_WORD);
    assign inst[0]       = hit_line[32*s1_addr.f.word +: 32];
    assign inst[1]       = hit_line[32*word_nxt +: 32];
    assign inst_pc       = s1_addr.raw;

endmodule : icache_lookup

`default_nettype wire

// File: src/icache_pkg.sv
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

    import fetch_pkg::*;

    // field view of a fetch address
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0]    tag;
        logic [`ICACHE_INDEX_W-1:0]  index;
        logic [`ICACHE_OFFSET_W-3:0] word;   // word inside the line
        logic [1:0]                  bsel;   // zero for aligned fetch
    } cache_addr_fields_t;

    // same 32 bits, seen as a word or as tag/index/offset
    typedef union packed {
        bus32_t             raw;
        cache_addr_fields_t f;
    } cache_addr_u;

    // tag array entry
    typedef struct packed {
        logic                     valid;
        logic [`ICACHE_TAG_W-1:0] tag;
    } tagv_t;

endpackage : icache_pkg

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

module icache_top
    import fetch_pkg::*, icache_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       fetch_valid,
    input  bus32_t     fetch_pc,
    input  logic       branch_flush,
    output logic       fetch_stall,
    output logic [1:0] inst_valid,
    output inst_pair_t inst,
    output bus32_t     inst_pc,
    output logic       rd_req,
    output bus32_t     rd_addr,
    input  logic       ret_valid,
    input  bus256_t    ret_data
);

    logic        req_valid;
    cache_addr_u req_addr;
    logic        miss;
    bus32_t      miss_addr;
    logic        fill_valid;
    bus256_t     fill_line;
    logic        busy;

    fetch_req_stage u_req (
        .clk(clk), .reset(reset), .fetch_valid(fetch_valid), .fetch_pc(fetch_pc),
        .branch_flush(branch_flush), .miss(miss), .busy(busy),
        .req_valid(req_valid), .req_addr(req_addr), .fetch_stall(fetch_stall)
    );

    icache_lookup u_lookup (
        .clk(clk), .reset(reset), .req_valid(req_valid), .req_addr(req_addr),
        .branch_flush(branch_flush), .fill_valid(fill_valid), .fill_line(fill_line),
        .miss(miss), .miss_addr(miss_addr), .inst_valid(inst_valid), .inst(inst),
        .inst_pc(inst_pc)
    );

    refill_unit u_refill (
        .clk(clk), .reset(reset), .miss(miss), .miss_addr(miss_addr),
        .branch_flush(branch_flush), .ret_valid(ret_valid), .ret_data(ret_data),
        .rd_req(rd_req), .rd_addr(rd_addr), .fill_valid(fill_valid),
        .fill_line(fill_line), .busy(busy)
    );

endmodule : icache_top

`default_nettype wire

// File: src/refill_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_cfg.svh"

module refill_unit
    import fetch_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    miss,
    input  bus32_t  miss_addr,
    input  logic    branch_flush,
    input  logic    ret_valid,
    input  bus256_t ret_data,
    output logic    rd_req,
    output bus32_t  rd_addr,
    output logic    fill_valid,
    output bus256_t fill_line,
    output logic    busy
);

    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_REQ     = 2'd1;
    localparam logic [1:0] ST_DISCARD = 2'd2;  // flushed, line still owed
    localparam logic [1:0] ST_FILL    = 2'd3;

    logic [1:0] state;
    logic [1:0] state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (miss) begin
                    state_nxt = ST_REQ;
                end
            end
            ST_REQ: begin
                if (ret_valid) begin
                    state_nxt = branch_flush ? ST_IDLE : ST_FILL;
                end else if (branch_flush) begin
                    state_nxt = ST_DISCARD;
                end
            end
            ST_DISCARD: begin
                if (ret_valid) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;  // fill lasts one cycle
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && miss) begin
            rd_addr <= {miss_addr[31:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};
        end
        if (state == ST_REQ && ret_valid) begin
            fill_line <= ret_data;
        end
    end

    assign rd_req     = (state == ST_REQ) || (state == ST_DISCARD);
    assign fill_valid = (state == ST_FILL);
    assign busy       = (state != ST_IDLE);

endmodule : refill_unit

`default_nettype wire

// File: vlog.f
+incdir+src
src/fetch_pkg.sv
src/icache_pkg.sv
src/fetch_req_stage.sv
src/icache_lookup.sv
src/refill_unit.sv
src/icache_top.sv
dv/icache_properties.sv
dv/icache_tb.sv
